// File: hw/switch_cfg_pkg.sv
// Switch configuration
// Port count, VC count and datapath width of the CICQ switch, plus the
// index widths derived from them. These fix the beat layout, so every
// block that builds or takes apart a beat reads them from here.

package switch_cfg_pkg;

    // radix of the crossbar
    localparam int PORT_COUNT = 4;

    // virtual channels behind each crosspoint
    localparam int VC_COUNT = 8;

    // payload bits per beat
    localparam int DATA_WIDTH = 32;

    // index widths, kept in step with the counts above
    localparam int PORT_IDX_WIDTH = $clog2(PORT_COUNT);
    localparam int VC_IDX_WIDTH = $clog2(VC_COUNT);

endpackage

// File: hw/switch_flit_pkg.sv
// Switch beat types
// The packed beat that travels through queues, arbiters and ports, and the
// port and VC index types that route it.

package switch_flit_pkg;

    import switch_cfg_pkg::*;

    // binary output port number
    typedef logic [PORT_IDX_WIDTH-1:0] port_idx_t;

    // virtual channel number
    typedef logic [VC_IDX_WIDTH-1:0] vc_idx_t;

    // one beat on the valid/ready stream
    // last closes a packet; dest and vc stay constant within one packet
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
        port_idx_t             dest;
        vc_idx_t               vc;
    } flit_t;

endpackage

// File: hw/vc_queue.sv
// VC queue
// Circular FIFO for one input, output and VC combination. The head beat is
// held in a register, so a beat written in one cycle shows on rd_flit in
// the next. Ready drops only while the queue is full.

`timescale 1ns/1ns

module vc_queue #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  switch_flit_pkg::flit_t wr_flit,
    input  logic                   wr_valid,
    output logic                   wr_ready,
    output switch_flit_pkg::flit_t rd_flit,
    output logic                   rd_valid,
    input  logic                   rd_ready
);

    import switch_flit_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    flit_t            mem [QUEUE_DEPTH];
    flit_t            head_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] rd_ptr_nxt;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    // count includes the beat shown at the head
    assign wr_ready = (count_q != CNT_W'(QUEUE_DEPTH));
    assign rd_valid = (count_q != '0);
    assign push = wr_valid && wr_ready;
    assign pop = rd_valid && rd_ready;

    assign rd_ptr_nxt = pop ? rd_ptr_q + PTR_W'(1) : rd_ptr_q;
    assign rd_flit = head_q;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= wr_flit;
        end
    end

    // head follows the next read slot every cycle
    // a write into that same slot only happens when the queue is about to
    // hold just this beat, so it is taken straight from the input
    always_ff @(posedge clk) begin
        if (push && (wr_ptr_q == rd_ptr_nxt)) begin
            head_q <= wr_flit;
        end else begin
            head_q <= mem[rd_ptr_nxt];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + PTR_W'(1);
            end
            rd_ptr_q <= rd_ptr_nxt;
            case ({push, pop})
                2'b10: count_q <= count_q + CNT_W'(1);
                2'b01: count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// File: hw/packet_arbiter.sv
// Packet arbiter
// Round-robin arbiter and multiplexer over N beat streams. The winner of
// the first beat of a packet keeps the output until its last beat is
// taken, so packets from different requesters never interleave.

`timescale 1ns/1ns

module packet_arbiter #(
    parameter int N = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  switch_flit_pkg::flit_t req_flit [N],
    input  logic [N-1:0]           req_valid,
    output logic [N-1:0]           req_ready,
    output switch_flit_pkg::flit_t grant_flit,
    output logic                   grant_valid,
    input  logic                   grant_ready
);

    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    logic [IDX_W-1:0] last_q;
    logic             lock_q;
    logic [IDX_W-1:0] sel;

    // first requester after the previous winner
    // the previous winner itself is checked last
    function automatic logic [IDX_W-1:0] rr_pick(
        input logic [N-1:0]     valid,
        input logic [IDX_W-1:0] last
    );
        int               cand;
        logic [IDX_W-1:0] pick;
        pick = last;
        for (int i = N; i >= 1; i--) begin
            cand = (int'(last) + i) % N;
            if (valid[cand]) begin
                pick = IDX_W'(cand);
            end
        end
        return pick;
    endfunction

    // while a packet is open the previous winner stays selected
    assign sel = lock_q ? last_q : rr_pick(req_valid, last_q);

    assign grant_flit = req_flit[sel];
    assign grant_valid = req_valid[sel];

    always_comb begin
        req_ready = '0;
        req_ready[sel] = grant_ready;
    end

    // start at N-1 so the first search after reset begins at requester 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q <= IDX_W'(N - 1);
            lock_q <= 1'b0;
        end else if (grant_valid && grant_ready) begin
            last_q <= sel;
            lock_q <= !grant_flit.last;
        end
    end

endmodule

// File: hw/input_port.sv
// Switch input port
// Steers each incoming beat into the one queue picked by its dest and vc,
// and runs one VC arbiter per output over that output's queues. The
// arbiter results form this input's row of crosspoints.

`timescale 1ns/1ns

module input_port #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  switch_flit_pkg::flit_t               in_flit,
    input  logic                                 in_valid,
    output logic                                 in_ready,
    output switch_flit_pkg::flit_t               xp_flit [switch_cfg_pkg::PORT_COUNT],
    output logic [switch_cfg_pkg::PORT_COUNT-1:0] xp_valid,
    input  logic [switch_cfg_pkg::PORT_COUNT-1:0] xp_ready
);

    import switch_cfg_pkg::*;
    import switch_flit_pkg::*;

    port_idx_t wr_dest;
    vc_idx_t   wr_vc;

    // write side, one strobe per queue
    logic [PORT_COUNT-1:0][VC_COUNT-1:0] wr_valid;
    logic [PORT_COUNT-1:0][VC_COUNT-1:0] wr_ready;

    // read side, grouped by output
    flit_t                               q_flit [PORT_COUNT][VC_COUNT];
    logic [PORT_COUNT-1:0][VC_COUNT-1:0] q_valid;
    logic [PORT_COUNT-1:0][VC_COUNT-1:0] q_ready;

    assign wr_dest = in_flit.dest;
    assign wr_vc = in_flit.vc;

    // only the addressed queue sees the valid
    always_comb begin
        wr_valid = '0;
        wr_valid[wr_dest][wr_vc] = in_valid;
    end

    // a full queue stalls only the traffic aimed at it
    assign in_ready = wr_ready[wr_dest][wr_vc];

    for (genvar o = 0; o < PORT_COUNT; o++) begin : g_out
        for (genvar v = 0; v < VC_COUNT; v++) begin : g_vc
            vc_queue #(
                .QUEUE_DEPTH(QUEUE_DEPTH)
            ) u_queue (
                .clk      (clk),
                .rst_n    (rst_n),
                .wr_flit  (in_flit),
                .wr_valid (wr_valid[o][v]),
                .wr_ready (wr_ready[o][v]),
                .rd_flit  (q_flit[o][v]),
                .rd_valid (q_valid[o][v]),
                .rd_ready (q_ready[o][v])
            );
        end

        // pick one VC toward output o, a whole packet at a time
        packet_arbiter #(
            .N(VC_COUNT)
        ) u_vc_arb (
            .clk         (clk),
            .rst_n       (rst_n),
            .req_flit    (q_flit[o]),
            .req_valid   (q_valid[o]),
            .req_ready   (q_ready[o]),
            .grant_flit  (xp_flit[o]),
            .grant_valid (xp_valid[o]),
            .grant_ready (xp_ready[o])
        );
    end

endmodule

// File: hw/switch_crossbar_cicq.sv
// CICQ packet switch
// Four-port crossbar with per-VC queues at every crosspoint. Each input
// port arbitrates its VCs per output; the crosspoint array is transposed
// so one output arbiter per port picks among the inputs.

`timescale 1ns/1ns

module switch_crossbar_cicq #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  switch_flit_pkg::flit_t               in_flit [switch_cfg_pkg::PORT_COUNT],
    input  logic [switch_cfg_pkg::PORT_COUNT-1:0] in_valid,
    output logic [switch_cfg_pkg::PORT_COUNT-1:0] in_ready,
    output switch_flit_pkg::flit_t               out_flit [switch_cfg_pkg::PORT_COUNT],
    output logic [switch_cfg_pkg::PORT_COUNT-1:0] out_valid,
    input  logic [switch_cfg_pkg::PORT_COUNT-1:0] out_ready
);

    import switch_cfg_pkg::*;
    import switch_flit_pkg::*;

    // crosspoints indexed [input][output]
    flit_t                                 xp_flit [PORT_COUNT][PORT_COUNT];
    logic [PORT_COUNT-1:0][PORT_COUNT-1:0] xp_valid;
    logic [PORT_COUNT-1:0][PORT_COUNT-1:0] xp_ready;

    // same crosspoints seen from the outputs, [output][input]
    flit_t                                 arb_flit [PORT_COUNT][PORT_COUNT];
    logic [PORT_COUNT-1:0][PORT_COUNT-1:0] arb_valid;
    logic [PORT_COUNT-1:0][PORT_COUNT-1:0] arb_ready;

    for (genvar p = 0; p < PORT_COUNT; p++) begin : g_in
        input_port #(
            .QUEUE_DEPTH(QUEUE_DEPTH)
        ) u_input (
            .clk      (clk),
            .rst_n    (rst_n),
            .in_flit  (in_flit[p]),
            .in_valid (in_valid[p]),
            .in_ready (in_ready[p]),
            .xp_flit  (xp_flit[p]),
            .xp_valid (xp_valid[p]),
            .xp_ready (xp_ready[p])
        );

        // crosspoint p->o lands in slot p of output arbiter o
        for (genvar o = 0; o < PORT_COUNT; o++) begin : g_xp
            assign arb_flit[o][p] = xp_flit[p][o];
            assign arb_valid[o][p] = xp_valid[p][o];
            assign xp_ready[p][o] = arb_ready[o][p];
        end
    end

    for (genvar o = 0; o < PORT_COUNT; o++) begin : g_out
        packet_arbiter #(
            .N(PORT_COUNT)
        ) u_out_arb (
            .clk         (clk),
            .rst_n       (rst_n),
            .req_flit    (arb_flit[o]),
            .req_valid   (arb_valid[o]),
            .req_ready   (arb_ready[o]),
            .grant_flit  (out_flit[o]),
            .grant_valid (out_valid[o]),
            .grant_ready (out_ready[o])
        );
    end

endmodule

// File: dv/switch_ref_model.sv
// Switch reference model
// Keeps every beat accepted at an input in a queue per output, input and
// VC, and checks each beat that leaves the switch against those queues.
// Also watches each output for interleaved packets.

`timescale 1ns/1ns

module switch_ref_model #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  switch_flit_pkg::flit_t                in_flit [switch_cfg_pkg::PORT_COUNT],
    input  logic [switch_cfg_pkg::PORT_COUNT-1:0] in_valid,
    input  logic [switch_cfg_pkg::PORT_COUNT-1:0] in_ready,
    input  switch_flit_pkg::flit_t                out_flit [switch_cfg_pkg::PORT_COUNT],
    input  logic [switch_cfg_pkg::PORT_COUNT-1:0] out_valid,
    input  logic [switch_cfg_pkg::PORT_COUNT-1:0] out_ready,
    output int                                    error_count,
    output int                                    sent_count,
    output int                                    recv_count,
    output int                                    pending
);

    import switch_cfg_pkg::*;
    import switch_flit_pkg::*;

    // expected beats per output, input and vc
    flit_t     exp_q [PORT_COUNT][PORT_COUNT][VC_COUNT][$];

    // packet currently open on each output
    logic      open_pkt [PORT_COUNT];
    port_idx_t open_src [PORT_COUNT];
    vc_idx_t   open_vc [PORT_COUNT];

    task automatic take_input(input int p, input flit_t beat);
        exp_q[beat.dest][p][beat.vc].push_back(beat);
        sent_count++;
        // the model queue mirrors the DUT queue since the arbiters hold no beats
        assert (exp_q[beat.dest][p][beat.vc].size() <= QUEUE_DEPTH) else begin
            error_count++;
            $display("input %0d took a beat for output %0d vc %0d while that queue was full",
                     p, beat.dest, beat.vc);
        end
    endtask

    // ready may only drop while the addressed queue holds QUEUE_DEPTH beats
    task automatic check_stall(input int p, input flit_t beat);
        int queued;
        queued = exp_q[beat.dest][p][beat.vc].size();
        assert (queued == QUEUE_DEPTH) else begin
            error_count++;
            $display("mismatch stall: input %0d expected ready %b actual %b at fill %0d",
                     p, 1'b1, 1'b0, queued);
        end
    endtask

    task automatic take_output(input int o, input flit_t got);
        port_idx_t src;
        flit_t     head;
        // source input sits in the top data bits
        src = got.data[DATA_WIDTH-1 -: PORT_IDX_WIDTH];
        recv_count++;
        assert (int'(got.dest) == o) else begin
            error_count++;
            $display("mismatch route: output %0d expected dest %0d actual %0d", o, o, got.dest);
        end
        assert (exp_q[o][src][got.vc].size() != 0) else begin
            error_count++;
            $display("output %0d delivered beat %h that no input sent", o, got);
        end
        if (exp_q[o][src][got.vc].size() != 0) begin
            head = exp_q[o][src][got.vc].pop_front();
            assert (got == head) else begin
                error_count++;
                $display("mismatch order: output %0d expected %h actual %h", o, head, got);
            end
        end
        assert (!open_pkt[o] || (src == open_src[o] && got.vc == open_vc[o])) else begin
            error_count++;
            $display("mismatch interleave: out %0d expected in %0d vc %0d actual in %0d vc %0d",
                     o, open_src[o], open_vc[o], src, got.vc);
        end
        open_pkt[o] = !got.last;
        open_src[o] = src;
        open_vc[o] = got.vc;
    endtask

    // sampled mid-cycle when inputs and outputs are settled
    always @(negedge clk) begin : track
        int total;
        if (!rst_n) begin
            error_count = 0;
            sent_count = 0;
            recv_count = 0;
            pending = 0;
            for (int o = 0; o < PORT_COUNT; o++) begin
                open_pkt[o] = 1'b0;
                open_src[o] = '0;
                open_vc[o] = '0;
            end
        end else begin
            // queue fill before this cycle's transfers matches the DUT count
            for (int p = 0; p < PORT_COUNT; p++) begin
                if (in_valid[p] && !in_ready[p]) begin
                    check_stall(p, in_flit[p]);
                end
            end
            // outputs go first so a beat cannot leave in the cycle it enters
            for (int o = 0; o < PORT_COUNT; o++) begin
                if (out_valid[o] && out_ready[o]) begin
                    take_output(o, out_flit[o]);
                end
            end
            for (int p = 0; p < PORT_COUNT; p++) begin
                if (in_valid[p] && in_ready[p]) begin
                    take_input(p, in_flit[p]);
                end
            end
            total = 0;
            for (int o = 0; o < PORT_COUNT; o++) begin
                for (int p = 0; p < PORT_COUNT; p++) begin
                    for (int v = 0; v < VC_COUNT; v++) begin
                        total += exp_q[o][p][v].size();
                    end
                end
            end
            pending = total;
        end
    end

endmodule

// File: dv/tb_switch_crossbar.sv
// CICQ switch testbench
// Random packets on all four inputs with random sink back-pressure. Output 0
// is held off for a while to show that other outputs keep flowing and that
// a full queue stalls its sender. A reference model checks every beat.

`timescale 1ns/1ns

module tb_switch_crossbar;

    import switch_cfg_pkg::*;
    import switch_flit_pkg::*;

    localparam int          CLK_PERIOD = 40;
    localparam int          QUEUE_DEPTH = 16;
    localparam int unsigned SEED = 32'hed71;
    localparam int          PACKETS_PER_PORT = 60;
    localparam int          MAX_LEN = 6;
    localparam int          BLOCK_CYCLES = 400;
    localparam int          DRAIN_CYCLES = 2000;
    localparam int          SEQ_W = DATA_WIDTH - PORT_IDX_WIDTH;

    logic                  clk;
    logic                  rst_n;
    flit_t                 in_flit [PORT_COUNT];
    logic [PORT_COUNT-1:0] in_valid;
    logic [PORT_COUNT-1:0] in_ready;
    flit_t                 out_flit [PORT_COUNT];
    logic [PORT_COUNT-1:0] out_valid;
    logic [PORT_COUNT-1:0] out_ready;

    int   errors;
    int   model_errors;
    int   sent_count;
    int   recv_count;
    int   pending;
    logic block_out0;
    logic stall_seen;

    switch_crossbar_cicq #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_flit   (in_flit),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_flit  (out_flit),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    switch_ref_model #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_model (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_flit     (in_flit),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_flit    (out_flit),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .error_count (model_errors),
        .sent_count  (sent_count),
        .recv_count  (recv_count),
        .pending     (pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_idle();
        assert (out_valid == '0) else begin
            errors++;
            $display("mismatch reset: out_valid expected %b actual %b",
                     {PORT_COUNT{1'b0}}, out_valid);
        end
        assert (in_ready == '1) else begin
            errors++;
            $display("mismatch reset: in_ready expected %b actual %b",
                     {PORT_COUNT{1'b1}}, in_ready);
        end
    endtask

    // one loop drives all inputs and each holds its beat until it is taken
    task automatic drive_traffic();
        int                    beats_left [PORT_COUNT];
        int                    pkts_left [PORT_COUNT];
        int                    seq [PORT_COUNT];
        port_idx_t             cur_dest [PORT_COUNT];
        vc_idx_t               cur_vc [PORT_COUNT];
        logic [PORT_COUNT-1:0] taken;
        flit_t                 beat;
        logic                  busy;
        for (int p = 0; p < PORT_COUNT; p++) begin
            beats_left[p] = 0;
            pkts_left[p] = PACKETS_PER_PORT;
            seq[p] = 0;
        end
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            taken = in_valid & in_ready;
            for (int p = 0; p < PORT_COUNT; p++) begin
                if (block_out0 && in_valid[p] && !in_ready[p] && in_flit[p].dest == '0) begin
                    stall_seen = 1'b1;
                end
            end
            @(posedge clk);
            #1;
            busy = 1'b0;
            for (int p = 0; p < PORT_COUNT; p++) begin
                if (taken[p]) begin
                    in_valid[p] = 1'b0;
                end
                // new packets start after an occasional idle cycle
                if (!in_valid[p] && beats_left[p] == 0 && pkts_left[p] > 0 &&
                    ($urandom % 8) != 0) begin
                    pkts_left[p]--;
                    beats_left[p] = int'($urandom % MAX_LEN) + 1;
                    cur_dest[p] = port_idx_t'($urandom % PORT_COUNT);
                    // one VC toward the blocked output so that its queue fills
                    if (block_out0 && cur_dest[p] == '0) begin
                        cur_vc[p] = '0;
                    end else begin
                        cur_vc[p] = vc_idx_t'($urandom % VC_COUNT);
                    end
                end
                if (!in_valid[p] && beats_left[p] > 0) begin
                    beat.data = {PORT_IDX_WIDTH'(p), SEQ_W'(seq[p])};
                    beat.last = (beats_left[p] == 1);
                    beat.dest = cur_dest[p];
                    beat.vc = cur_vc[p];
                    in_flit[p] = beat;
                    in_valid[p] = 1'b1;
                    beats_left[p]--;
                    seq[p]++;
                end
                if (in_valid[p] || beats_left[p] > 0 || pkts_left[p] > 0) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    task automatic hold_output_zero();
        int other_beats;
        other_beats = 0;
        repeat (BLOCK_CYCLES) begin
            @(negedge clk);
            for (int o = 1; o < PORT_COUNT; o++) begin
                if (out_valid[o] && out_ready[o]) begin
                    other_beats++;
                end
            end
        end
        assert (stall_seen) else begin
            errors++;
            $display("backpressure: no input saw in_ready low while output 0 was held off");
        end
        assert (other_beats > 0) else begin
            errors++;
            $display("backpressure: no beat reached the other outputs while output 0 was held off");
        end
        block_out0 = 1'b0;
    endtask

    // sink ready is low about 30% of the time
    task automatic throttle_outputs();
        forever begin
            @(posedge clk);
            #1;
            for (int o = 0; o < PORT_COUNT; o++) begin
                out_ready[o] = (($urandom % 10) >= 3);
            end
            if (block_out0) begin
                out_ready[0] = 1'b0;
            end
        end
    endtask

    // limit grows by 50 cycles for every beat sent
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 50 * sent_count + 1000) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run stopped after %0d cycles, %0d beats sent, %0d received",
                 cycles, sent_count, recv_count);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main
        int total_errors;
        int drain_cycles;
        errors = 0;
        stall_seen = 1'b0;
        block_out0 = 1'b0;
        rst_n = 1'b0;
        in_valid = '0;
        out_ready = '1;
        for (int p = 0; p < PORT_COUNT; p++) begin
            in_flit[p] = '0;
        end
        void'($urandom(SEED));
        fork
            throttle_outputs();
        join_none
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_idle();
        block_out0 = 1'b1;
        fork
            drive_traffic();
            hold_output_zero();
        join
        // bounded wait for the queues to empty
        drain_cycles = 0;
        while (pending != 0 && drain_cycles < DRAIN_CYCLES) begin
            @(posedge clk);
            drain_cycles++;
        end
        repeat (10) @(posedge clk);
        assert (pending == 0) else begin
            errors++;
            $display("drain: %0d beats never left the switch", pending);
        end
        assert (recv_count == sent_count) else begin
            errors++;
            $display("mismatch count: expected %0d actual %0d", sent_count, recv_count);
        end
        total_errors = errors + model_errors;
        $display("errors: %0d (testbench %0d, model %0d), beats sent %0d, received %0d",
                 total_errors, errors, model_errors, sent_count, recv_count);
        if (total_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: list.f
hw/switch_cfg_pkg.sv
hw/switch_flit_pkg.sv
hw/vc_queue.sv
hw/packet_arbiter.sv
hw/input_port.sv
hw/switch_crossbar_cicq.sv
dv/switch_ref_model.sv
dv/tb_switch_crossbar.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_switch_crossbar -f list.f -o sim_switch \
    && ./obj_dir/sim_switch > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "^Simulation passed$" sim.log && echo "result: PASS" \
    || { echo "result: FAIL"; exit 1; }
